// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --timing --assert
SIM_FLAGS  = --binary -j 0
TOP        = tb_axil_read_split
FILELIST   = axil_read_split.f
OBJ_DIR    = obj_dir
PASS_MSG   = All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== axil_read_split.f ====
src/axil_read_pkg.sv
src/ar_decode.sv
src/read_collect.sv
src/return_fifo.sv
src/axil_read_split.sv
bench/axil_read_split_props.sv
bench/tb_axil_read_split.sv

// ==== bench/axil_read_split_props.sv ====
`timescale 1ns/10ps

module axil_read_split_props #(
	parameter int NS = 3
) (
	input logic          S_AXI_ACLK,
	input logic          S_AXI_ARESETN,
	input logic          i_arvalid,
	input logic          i_arready,
	input logic          i_rvalid,
	input logic          i_rready,
	input logic [NS-1:0] i_sel
);

	// Failed assertions so far
	int fail_count = 0;

	// At most one slave addressed per clock
	sel_onehot: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$onehot0(i_sel))
	else
	begin
		fail_count++;
		$error("Slave select is not zero or one-hot");
	end

	// A select pulse only follows an accepted AR
	sel_after_ar: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(|i_sel) |-> $past(i_arvalid && i_arready))
	else
	begin
		fail_count++;
		$error("Slave select without a preceding AR transfer");
	end

	// R beat held until the master takes it
	rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(i_rvalid && !i_rready) |=> i_rvalid)
	else
	begin
		fail_count++;
		$error("RVALID dropped before an R transfer");
	end

endmodule

bind axil_read_split axil_read_split_props #(.NS(NS)) u_props (
	.S_AXI_ACLK(S_AXI_ACLK),
	.S_AXI_ARESETN(S_AXI_ARESETN),
	.i_arvalid(S_AXI_ARVALID),
	.i_arready(S_AXI_ARREADY),
	.i_rvalid(S_AXI_RVALID),
	.i_rready(S_AXI_RREADY),
	.i_sel(M_AXI_ARVALID)
);

// ==== bench/tb_axil_read_split.sv ====
`timescale 1ns/10ps

module tb_axil_read_split;
	import axil_read_pkg::*;

	localparam int NS = 3;
	localparam int LGFLEN = 3;
	localparam int DEPTH = 1 << LGFLEN;
	localparam int NUM_READS = 400;
	localparam int STREAM_LEN = 40;
	// Budget of 20 clocks per read across all phases, plus slack for reset and drains
	localparam int WATCHDOG_CYCLES = (NUM_READS + 2 * DEPTH + STREAM_LEN) * 20 + 500;

	logic               S_AXI_ACLK;
	logic               S_AXI_ARESETN;
	logic               S_AXI_ARVALID;
	logic               S_AXI_ARREADY;
	addr_t              S_AXI_ARADDR;
	prot_t              S_AXI_ARPROT;
	logic               S_AXI_RVALID;
	logic               S_AXI_RREADY;
	data_t              S_AXI_RDATA;
	resp_t              S_AXI_RRESP;
	logic [NS-1:0]      M_AXI_ARVALID;
	addr_t              M_AXI_ARADDR;
	prot_t              M_AXI_ARPROT;
	logic [NS*DATA_W-1:0] M_AXI_RDATA;
	logic [NS*2-1:0]    M_AXI_RRESP;

	// Select and address seen by the slave model one falling edge back
	logic [NS-1:0] prev_sel;
	addr_t         prev_addr;

	// Reference model with one entry per accepted read in AR order
	read_rsp_t exp_q[$];

	// Requests the slaves must see, mapped reads only
	read_req_t req_q[$];

	logic ar_fire;
	logic r_fire;
	int   checks = 0;
	int   errors = 0;

	axil_read_split #(
		.NS(NS),
		.LGFLEN(LGFLEN)
	) dut (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	//////////////////////////////
	// Slave rule helpers
	//////////////////////////////

	// Slave index in the top byte and word address below
	function automatic data_t slave_data(input int k, input addr_t a);
		return {8'(k), a[25:2]};
	endfunction

	// Slave 2 flags a slave error on odd words
	function automatic resp_t slave_resp(input int k, input addr_t a);
		return (k == 2 && a[2]) ? 2'b10 : RESP_OKAY;
	endfunction

	function automatic read_rsp_t expect_rsp(input addr_t a);
		read_rsp_t rsp;
		int        region;
		region = int'(a[ADDR_W-1 -: REGION_W]);
		if (region >= NS)
		begin
			rsp.data = '0;
			rsp.resp = RESP_DECERR;
		end
		else
		begin
			rsp.data = slave_data(region, a);
			rsp.resp = slave_resp(region, a);
		end
		return rsp;
	endfunction

	// Selected slave answers from the next falling edge for one full clock
	always @(negedge S_AXI_ACLK)
	begin
		for (int k = 0; k < NS; k++)
			if (prev_sel[k])
			begin
				M_AXI_RDATA[k*DATA_W +: DATA_W] <= slave_data(k, prev_addr);
				M_AXI_RRESP[2*k +: 2] <= slave_resp(k, prev_addr);
			end
		prev_sel <= M_AXI_ARVALID;
		prev_addr <= M_AXI_ARADDR;
	end

	//////////////////////////////
	// Checks and bus cycles
	//////////////////////////////

	task automatic check_value(input string what, input data_t got, input data_t expv);
		checks++;
		if (got !== expv)
		begin
			errors++;
			$display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, expv);
		end
	endtask

	// Every select pulse carries the oldest mapped request to its own slave
	always @(negedge S_AXI_ACLK)
	begin
		read_req_t exp_req;
		if (M_AXI_ARVALID != '0)
		begin
			if (req_q.size() == 0)
			begin
				errors++;
				$display("Slave select at %0t ns with no mapped read outstanding", $time);
			end
			else
			begin
				exp_req = req_q.pop_front();
				check_value("M_AXI_ARVALID", data_t'(M_AXI_ARVALID),
					data_t'(1) << exp_req.addr[ADDR_W-1 -: REGION_W]);
				check_value("M_AXI_ARADDR", M_AXI_ARADDR, exp_req.addr);
				check_value("M_AXI_ARPROT", data_t'(M_AXI_ARPROT), data_t'(exp_req.prot));
			end
		end
	end

	// Runs from one falling edge to the next and scores the handshakes
	task automatic drive_cycle(input logic arv, input addr_t a, input prot_t p, input logic rr);
		read_rsp_t exp_rsp;
		read_req_t req;
		S_AXI_ARVALID = arv;
		S_AXI_ARADDR = a;
		S_AXI_ARPROT = p;
		S_AXI_RREADY = rr;
		// Ready and valid come from flops only, so they are settled here
		ar_fire = arv && S_AXI_ARREADY;
		r_fire = rr && S_AXI_RVALID;
		if (r_fire)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("R transfer at %0t ns with no read outstanding", $time);
			end
			else
			begin
				exp_rsp = exp_q.pop_front();
				check_value("RRESP", data_t'(S_AXI_RRESP), data_t'(exp_rsp.resp));
				// Unmapped data is undefined
				if (exp_rsp.resp != RESP_DECERR)
					check_value("RDATA", S_AXI_RDATA, exp_rsp.data);
			end
		end
		if (ar_fire)
		begin
			exp_q.push_back(expect_rsp(a));
			// Unmapped regions raise no select pulse
			if (int'(a[ADDR_W-1 -: REGION_W]) < NS)
			begin
				req.addr = a;
				req.prot = p;
				req_q.push_back(req);
			end
		end
		@(negedge S_AXI_ACLK);
	endtask

	task automatic drain_results();
		while (exp_q.size() != 0)
			drive_cycle(1'b0, '0, '0, 1'b1);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		int   issued;
		logic pending;
		addr_t addr;
		prot_t prot;
		void'($urandom(39));
		S_AXI_ARESETN = 1'b0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_ARADDR = '0;
		S_AXI_ARPROT = '0;
		S_AXI_RREADY = 1'b0;
		M_AXI_RDATA = '0;
		M_AXI_RRESP = '0;
		prev_sel = '0;
		prev_addr = '0;
		repeat (2) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;

		// Idle state out of reset
		check_value("ARREADY after reset", data_t'(S_AXI_ARREADY), 1);
		check_value("RVALID after reset", data_t'(S_AXI_RVALID), 0);
		check_value("M_AXI_ARVALID after reset", data_t'(M_AXI_ARVALID), 0);

		// Credits run out after exactly one FIFO's worth of reads
		for (int i = 0; i < DEPTH; i++)
		begin
			check_value("ARREADY below credit limit", data_t'(S_AXI_ARREADY), 1);
			drive_cycle(1'b1, addr_t'($urandom), prot_t'($urandom), 1'b0);
		end
		check_value("ARREADY at credit limit", data_t'(S_AXI_ARREADY), 0);
		while (!S_AXI_RVALID)
			drive_cycle(1'b0, '0, '0, 1'b0);
		check_value("ARREADY with results waiting", data_t'(S_AXI_ARREADY), 0);
		drive_cycle(1'b0, '0, '0, 1'b1);
		check_value("ARREADY after one R transfer", data_t'(S_AXI_ARREADY), 1);
		drain_results();

		// Streaming gives four clocks to the first result then one per clock
		for (int i = 0; i < STREAM_LEN; i++)
		begin
			check_value("ARREADY while streaming", data_t'(S_AXI_ARREADY), 1);
			if (i >= 4)
				check_value("RVALID while streaming", data_t'(S_AXI_RVALID), 1);
			drive_cycle(1'b1, addr_t'($urandom), prot_t'($urandom), 1'b1);
		end
		drain_results();

		// Random traffic with AR held stable until accepted
		issued = 0;
		pending = 1'b0;
		addr = '0;
		prot = '0;
		while (issued < NUM_READS)
		begin
			if (!pending)
			begin
				pending = ($urandom % 4 != 0);
				addr = addr_t'($urandom);
				prot = prot_t'($urandom);
			end
			drive_cycle(pending, addr, prot, ($urandom % 3 != 0));
			if (ar_fire)
			begin
				pending = 1'b0;
				issued++;
			end
		end
		drain_results();
		check_value("RVALID after drain", data_t'(S_AXI_RVALID), 0);
		check_value("mapped reads without a select pulse", data_t'(req_q.size()), 0);

		errors += dut.u_props.fail_count;
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge S_AXI_ACLK);
		$display("Timeout: the tests did not finish within %0d clocks", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== src/ar_decode.sv ====
`timescale 1ns/10ps

module ar_decode #(
	parameter int NS = 3,
	parameter int LGFLEN = 3
) (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_arvalid,
	output logic                      o_arready,
	input  axil_read_pkg::addr_t      i_araddr,
	input  axil_read_pkg::prot_t      i_arprot,
	input  logic                      i_pop,
	output logic [NS-1:0]             o_sel,
	output axil_read_pkg::read_req_t  o_req,
	output logic                      o_dcd_valid,
	output logic                      o_no_match
);
	import axil_read_pkg::*;

	// Number of results the return FIFO can hold
	localparam int DEPTH = 1 << LGFLEN;

	logic                ar_xfer;
	logic [REGION_W-1:0] region;
	logic [NS-1:0]       dcd_sel;
	logic                dcd_miss;
	logic [LGFLEN:0]     credit;
	logic                full;

	//////////////////////////////
	// AR handshake
	//////////////////////////////

	// Hold off new requests once every FIFO slot is spoken for
	assign o_arready = !full;
	assign ar_xfer = i_arvalid && o_arready;

	//////////////////////////////
	// Region decode
	//////////////////////////////

	// Region is the top field of the incoming address
	assign region = i_araddr[ADDR_W-1 -: REGION_W];

	// One select bit per mapped region
	always_comb
	begin
		dcd_sel = '0;
		for (int k = 0; k < NS; k++)
			dcd_sel[k] = (region == REGION_W'(k));
	end

	// Regions at or above NS have no slave behind them
	assign dcd_miss = (int'(region) >= NS);

	// Select pulse lasts exactly the cycle after the transfer
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_sel <= '0;
			o_dcd_valid <= 1'b0;
			o_no_match <= 1'b0;
		end
		else
		begin
			o_sel <= ar_xfer ? dcd_sel : '0;
			o_dcd_valid <= ar_xfer;
			o_no_match <= ar_xfer && dcd_miss;
		end
	end

	// Address and protection shared by all slaves
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_xfer)
		begin
			o_req.addr <= i_araddr;
			o_req.prot <= i_arprot;
		end
	end

	//////////////////////////////
	// Credit counter
	//////////////////////////////

	// Reads in flight: accepted on AR, retired on R
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			credit <= '0;
			full <= 1'b0;
		end
		else
		begin
			case ({ar_xfer, i_pop})
				2'b10:
				begin
					credit <= credit + 1'b1;
					full <= (credit == (LGFLEN+1)'(DEPTH - 1));
				end
				2'b01:
				begin
					credit <= credit - 1'b1;
					full <= 1'b0;
				end
				// Both or neither leaves the count alone
				default:
				begin
				end
			endcase
		end
	end

endmodule

// ==== src/axil_read_pkg.sv ====
package axil_read_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////

	// Address and data width of the shared AXI-lite port
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Region field taken from the top of the address
	localparam int REGION_W = 2;

	//////////////////////////////
	// Response codes
	//////////////////////////////

	// Normal completion
	localparam logic [1:0] RESP_OKAY = 2'b00;

	// Interconnect error, returned when no slave is mapped
	localparam logic [1:0] RESP_DECERR = 2'b11;

	//////////////////////////////
	// Vector types
	//////////////////////////////

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [1:0] resp_t;
	typedef logic [2:0] prot_t;

	//////////////////////////////
	// Request and response bundles
	//////////////////////////////

	// Registered AR request as presented to every slave
	typedef struct packed {
		addr_t addr;
		prot_t prot;
	} read_req_t;

	// One read result, the word held by the return FIFO
	typedef struct packed {
		data_t data;
		resp_t resp;
	} read_rsp_t;

endpackage

// ==== src/axil_read_split.sv ====
`timescale 1ns/10ps

module axil_read_split #(
	parameter int NS = 3,
	parameter int LGFLEN = 3
) (
	input  logic                                S_AXI_ACLK,
	input  logic                                S_AXI_ARESETN,
	// Master side, AR channel
	input  logic                                S_AXI_ARVALID,
	output logic                                S_AXI_ARREADY,
	input  axil_read_pkg::addr_t                S_AXI_ARADDR,
	input  axil_read_pkg::prot_t                S_AXI_ARPROT,
	// Master side, R channel
	output logic                                S_AXI_RVALID,
	input  logic                                S_AXI_RREADY,
	output axil_read_pkg::data_t                S_AXI_RDATA,
	output axil_read_pkg::resp_t                S_AXI_RRESP,
	// Slave side
	output logic [NS-1:0]                       M_AXI_ARVALID,
	output axil_read_pkg::addr_t                M_AXI_ARADDR,
	output axil_read_pkg::prot_t                M_AXI_ARPROT,
	input  logic [NS*axil_read_pkg::DATA_W-1:0] M_AXI_RDATA,
	input  logic [NS*2-1:0]                     M_AXI_RRESP
);
	import axil_read_pkg::*;

	read_req_t dcd_req;
	logic      dcd_valid;
	logic      dcd_no_match;
	logic      rsp_valid;
	read_rsp_t collect_rsp;
	read_rsp_t fifo_rsp;
	logic      fifo_pop;

	//////////////////////////////
	// Request path
	//////////////////////////////

	ar_decode #(
		.NS(NS),
		.LGFLEN(LGFLEN)
	) u_ar_decode (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_arvalid(S_AXI_ARVALID),
		.o_arready(S_AXI_ARREADY),
		.i_araddr(S_AXI_ARADDR),
		.i_arprot(S_AXI_ARPROT),
		.i_pop(fifo_pop),
		.o_sel(M_AXI_ARVALID),
		.o_req(dcd_req),
		.o_dcd_valid(dcd_valid),
		.o_no_match(dcd_no_match)
	);

	// Every slave sees the same registered request
	assign M_AXI_ARADDR = dcd_req.addr;
	assign M_AXI_ARPROT = dcd_req.prot;

	//////////////////////////////
	// Response path
	//////////////////////////////

	read_collect #(
		.NS(NS)
	) u_read_collect (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_sel(M_AXI_ARVALID),
		.i_dcd_valid(dcd_valid),
		.i_no_match(dcd_no_match),
		.i_rdata_all(M_AXI_RDATA),
		.i_rresp_all(M_AXI_RRESP),
		.o_rsp_valid(rsp_valid),
		.o_rsp(collect_rsp)
	);

	// Buffer absorbs RREADY back-pressure
	return_fifo #(
		.LGFLEN(LGFLEN)
	) u_return_fifo (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wr(rsp_valid),
		.i_rsp(collect_rsp),
		.i_rready(S_AXI_RREADY),
		.o_rvalid(S_AXI_RVALID),
		.o_rsp(fifo_rsp),
		.o_pop(fifo_pop)
	);

	assign S_AXI_RDATA = fifo_rsp.data;
	assign S_AXI_RRESP = fifo_rsp.resp;

endmodule

// ==== src/read_collect.sv ====
`timescale 1ns/10ps

module read_collect #(
	parameter int NS = 3
) (
	input  logic                                S_AXI_ACLK,
	input  logic                                S_AXI_ARESETN,
	input  logic [NS-1:0]                       i_sel,
	input  logic                                i_dcd_valid,
	input  logic                                i_no_match,
	input  logic [NS*axil_read_pkg::DATA_W-1:0] i_rdata_all,
	input  logic [NS*2-1:0]                     i_rresp_all,
	output logic                                o_rsp_valid,
	output axil_read_pkg::read_rsp_t            o_rsp
);
	import axil_read_pkg::*;

	// Slave index width, at least one bit
	localparam int IDX_W = (NS > 1) ? $clog2(NS) : 1;

	logic [IDX_W-1:0] sel_idx;
	logic [IDX_W-1:0] s1_idx;
	logic             s1_no_match;
	logic             s1_valid;

	// One-hot select to binary index
	always_comb
	begin
		sel_idx = '0;
		for (int k = 0; k < NS; k++)
			if (i_sel[k])
				sel_idx = sel_idx | IDX_W'(k);
	end

	//////////////////////////////
	// Stage 1, slave is answering
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			s1_valid <= 1'b0;
		else
			s1_valid <= i_dcd_valid;
	end

	// Remember who was asked while the slave drives its answer
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_dcd_valid)
		begin
			s1_idx <= sel_idx;
			s1_no_match <= i_no_match;
		end
	end

	//////////////////////////////
	// Stage 2, capture the answer
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rsp_valid <= 1'b0;
		else
			o_rsp_valid <= s1_valid;
	end

	// Unmapped reads get the interconnect error, data left as is
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (s1_valid)
		begin
			o_rsp.data <= i_rdata_all[DATA_W*s1_idx +: DATA_W];
			if (s1_no_match)
				o_rsp.resp <= RESP_DECERR;
			else
				o_rsp.resp <= i_rresp_all[2*s1_idx +: 2];
		end
	end

endmodule

// ==== src/return_fifo.sv ====
`timescale 1ns/10ps

module return_fifo #(
	parameter int LGFLEN = 3
) (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_wr,
	input  axil_read_pkg::read_rsp_t  i_rsp,
	input  logic                      i_rready,
	output logic                      o_rvalid,
	output axil_read_pkg::read_rsp_t  o_rsp,
	output logic                      o_pop
);
	import axil_read_pkg::*;

	// Number of stored results
	localparam int DEPTH = 1 << LGFLEN;

	// Result storage
	read_rsp_t mem [DEPTH];

	// Pointers carry one extra bit to tell full from empty
	logic [LGFLEN:0] wr_ptr;
	logic [LGFLEN:0] rd_ptr;

	//////////////////////////////
	// Write side
	//////////////////////////////

	// Upstream credits guarantee a free slot on every write
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr)
			mem[wr_ptr[LGFLEN-1:0]] <= i_rsp;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_ptr <= '0;
		else if (i_wr)
			wr_ptr <= wr_ptr + 1'b1;
	end

	//////////////////////////////
	// Read side, R channel
	//////////////////////////////

	// Anything stored is a pending R beat
	assign o_rvalid = (wr_ptr != rd_ptr);

	// R transfer retires the head entry
	assign o_pop = o_rvalid && i_rready;

	// Head of the queue, visible the cycle after it was written
	assign o_rsp = mem[rd_ptr[LGFLEN-1:0]];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_ptr <= '0;
		else if (o_pop)
			rd_ptr <= rd_ptr + 1'b1;
	end

endmodule
